/* Bender.yml */
package:
  name: udp_pattern

sources:
  - src/udp_pattern_pkg.sv
  - src/command_decoder.sv
  - src/pattern_source.sv
  - src/udp_tx_header.sv
  - src/udp_pattern_top.sv
  - target: test
    files:
      - tests/tb_clock_gen.sv
      - tests/tb_udp_pattern.sv

/* build.f */
src/udp_pattern_pkg.sv
src/command_decoder.sv
src/pattern_source.sv
src/udp_tx_header.sv
src/udp_pattern_top.sv
tests/tb_clock_gen.sv
tests/tb_udp_pattern.sv

/* src/command_decoder.sv */
// Receive-side filter that turns INIT/FINI datagrams on the command port into the run state
`timescale 1ns/100ps
`default_nettype none

module command_decoder (
    input  wire                             clk,
    input  wire                             rst,
    input  wire  udp_pattern_pkg::udp_rx_hdr_t rx_hdr,
    input  wire                             rx_hdr_valid,
    input  wire  udp_pattern_pkg::axis_word_t  rx_payload,
    input  wire                             rx_payload_valid,
    output logic                            running,
    output udp_pattern_pkg::ip_addr_t       reply_ip
);
    import udp_pattern_pkg::*;

    logic     port_match_q;
    logic     first_pending_q;
    logic     hdr_match;
    logic     port_match;
    logic     cmd_hit;
    rx_word_u cmd_word;

    assign hdr_match = rx_hdr_valid && (rx_hdr.dest_port == CMD_PORT);

    // Header may come on the same cycle as the first payload word
    assign port_match = rx_hdr_valid ? hdr_match : port_match_q;

    assign cmd_word.raw = rx_payload.data;

    // Only the first word of a datagram carries a command
    assign cmd_hit = rx_payload_valid && first_pending_q && port_match &&
                     (cmd_word.cmd.marker == CMD_MARKER);

    always_ff @(posedge clk) begin
        if (rst) begin
            port_match_q <= 1'b0;
        end else if (rx_hdr_valid) begin
            port_match_q <= hdr_match;
        end
    end

    // Set again after each last word so the next datagram starts fresh
    always_ff @(posedge clk) begin
        if (rst) begin
            first_pending_q <= 1'b1;
        end else if (rx_payload_valid) begin
            first_pending_q <= rx_payload.last;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            running <= 1'b0;
        end else if (cmd_hit) begin
            if (cmd_word.cmd.opcode == CMD_START) begin
                running <= 1'b1;
            end else if (cmd_word.cmd.opcode == CMD_STOP) begin
                running <= 1'b0;
            end
        end
    end

    // Sender of the last command datagram receives the stream
    always_ff @(posedge clk) begin
        if (rst) begin
            reply_ip <= DEFAULT_DEST_IP;
        end else if (hdr_match) begin
            reply_ip <= rx_hdr.source_ip;
        end
    end

endmodule

`default_nettype wire

/* src/pattern_source.sv */
// Pattern word generator that streams framed ASCII test words while running is high
`timescale 1ns/100ps
`default_nettype none

module pattern_source #(
    parameter int FRAME_WORDS = 1024
) (
    input  wire                            clk,
    input  wire                            rst,
    input  wire                            running,
    output wire udp_pattern_pkg::axis_word_t tx_payload,
    output logic                           tx_payload_valid,
    input  wire                            tx_payload_ready
);
    import udp_pattern_pkg::*;

    localparam int CNT_W = (FRAME_WORDS > 1) ? $clog2(FRAME_WORDS) : 1;
    localparam logic [CNT_W-1:0] LAST_INDEX = CNT_W'(FRAME_WORDS - 1);

    data_word_t       word_q;
    logic [2:0]       pattern_idx_q;
    logic [CNT_W-1:0] word_cnt_q;
    logic             fire;
    logic             last_word;

    assign fire = tx_payload_valid && tx_payload_ready;
    assign last_word = (word_cnt_q == LAST_INDEX);

    // Valid tracks running one cycle late
    always_ff @(posedge clk) begin
        if (rst) begin
            tx_payload_valid <= 1'b0;
        end else begin
            tx_payload_valid <= running;
        end
    end

    // Banner first, then the eight patterns in a loop
    always_ff @(posedge clk) begin
        if (rst) begin
            word_q        <= BANNER_WORD;
            pattern_idx_q <= 3'd0;
        end else if (fire) begin
            word_q        <= PATTERN_WORDS[pattern_idx_q];
            pattern_idx_q <= pattern_idx_q + 3'd1;
        end
    end

    // Frame boundaries are independent of the pattern position
    always_ff @(posedge clk) begin
        if (rst) begin
            word_cnt_q <= '0;
        end else if (fire) begin
            if (last_word) begin
                word_cnt_q <= '0;
            end else begin
                word_cnt_q <= word_cnt_q + 1'b1;
            end
        end
    end

    assign tx_payload = '{data: word_q, keep: 8'hFF, last: last_word};

endmodule

`default_nettype wire

/* src/udp_pattern_pkg.sv */
// Shared types and constants for the UDP pattern source; imported by every RTL module
`default_nettype none

package udp_pattern_pkg;

    typedef logic [63:0] data_word_t;
    typedef logic [7:0]  keep_t;
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_port_t;

    // Command endpoint and transmit addressing
    localparam udp_port_t CMD_PORT        = 16'd1234;
    localparam udp_port_t TX_SOURCE_PORT  = 16'd1234;
    localparam udp_port_t TX_DEST_PORT    = 16'd9999;
    localparam ip_addr_t  DEFAULT_DEST_IP = {8'd192, 8'd168, 8'd1, 8'd100};
    localparam ip_addr_t  LOCAL_IP        = {8'd192, 8'd168, 8'd1, 8'd128};
    localparam logic [7:0] TX_TTL         = 8'd64;

    // ASCII is little-endian with the first character in the low byte
    localparam logic [31:0] CMD_MARKER = 32'h2E2E_2E2E;
    localparam logic [31:0] CMD_START  = 32'h5449_4E49;
    localparam logic [31:0] CMD_STOP   = 32'h494E_4946;

    // "\n.INIT.\n"
    localparam data_word_t BANNER_WORD = 64'h0A2E_5449_4E49_2E0A;

    localparam data_word_t PATTERN_WORDS [0:7] = '{
        64'h4847_4645_4443_4241,
        64'h504F_4E4D_4C4B_4A49,
        64'h5857_5655_5453_5251,
        64'h0A5F_5E5D_5C5B_5A59,
        64'h6867_6665_6463_6261,
        64'h706F_6E6D_6C6B_6A69,
        64'h7877_7675_7473_7271,
        64'h0A7F_7E7D_7C7B_7A79
    };

    typedef struct packed {
        logic [31:0] opcode;
        logic [31:0] marker;
    } rx_cmd_t;

    // First payload word, seen as raw data or as a command
    typedef union packed {
        data_word_t raw;
        rx_cmd_t    cmd;
    } rx_word_u;

    typedef struct packed {
        ip_addr_t  source_ip;
        udp_port_t dest_port;
    } udp_rx_hdr_t;

    typedef struct packed {
        data_word_t data;
        keep_t      keep;
        logic       last;
    } axis_word_t;

    typedef struct packed {
        ip_addr_t    dest_ip;
        ip_addr_t    source_ip;
        udp_port_t   source_port;
        udp_port_t   dest_port;
        logic [15:0] length;
        logic [7:0]  ttl;
    } udp_tx_hdr_t;

endpackage

`default_nettype wire

/* src/udp_pattern_top.sv */
// Top level of the UDP-controlled pattern source; sits behind a UDP/IP stack
`timescale 1ns/100ps
`default_nettype none

module udp_pattern_top #(
    parameter int FRAME_WORDS = 1024
) (
    input  wire                               clk,
    input  wire                               rst,

    // UDP receive side is always accepted
    input  wire udp_pattern_pkg::udp_rx_hdr_t rx_hdr,
    input  wire                               rx_hdr_valid,
    input  wire udp_pattern_pkg::axis_word_t  rx_payload,
    input  wire                               rx_payload_valid,

    // UDP transmit side
    output wire udp_pattern_pkg::udp_tx_hdr_t tx_hdr,
    output wire                               tx_hdr_valid,
    input  wire                               tx_hdr_ready,
    output wire udp_pattern_pkg::axis_word_t  tx_payload,
    output wire                               tx_payload_valid,
    input  wire                               tx_payload_ready,

    // Status LED
    output wire                               running
);
    import udp_pattern_pkg::*;

    wire ip_addr_t reply_ip;

    command_decoder u_command_decoder (
        .clk              (clk),
        .rst              (rst),
        .rx_hdr           (rx_hdr),
        .rx_hdr_valid     (rx_hdr_valid),
        .rx_payload       (rx_payload),
        .rx_payload_valid (rx_payload_valid),
        .running          (running),
        .reply_ip         (reply_ip)
    );

    pattern_source #(
        .FRAME_WORDS (FRAME_WORDS)
    ) u_pattern_source (
        .clk              (clk),
        .rst              (rst),
        .running          (running),
        .tx_payload       (tx_payload),
        .tx_payload_valid (tx_payload_valid),
        .tx_payload_ready (tx_payload_ready)
    );

    // Watches the payload handshake to place one header per frame
    udp_tx_header #(
        .FRAME_WORDS (FRAME_WORDS)
    ) u_udp_tx_header (
        .clk              (clk),
        .rst              (rst),
        .reply_ip         (reply_ip),
        .tx_payload_valid (tx_payload_valid),
        .tx_payload_ready (tx_payload_ready),
        .tx_payload_last  (tx_payload.last),
        .tx_hdr           (tx_hdr),
        .tx_hdr_valid     (tx_hdr_valid),
        .tx_hdr_ready     (tx_hdr_ready)
    );

endmodule

`default_nettype wire

/* src/udp_tx_header.sv */
// Transmit header builder that offers one UDP header at the start of every frame
`timescale 1ns/100ps
`default_nettype none

module udp_tx_header #(
    parameter int FRAME_WORDS = 1024
) (
    input  wire                             clk,
    input  wire                             rst,
    input  wire udp_pattern_pkg::ip_addr_t  reply_ip,
    input  wire                             tx_payload_valid,
    input  wire                             tx_payload_ready,
    input  wire                             tx_payload_last,
    output wire udp_pattern_pkg::udp_tx_hdr_t tx_hdr,
    output wire                             tx_hdr_valid,
    input  wire                             tx_hdr_ready
);
    import udp_pattern_pkg::*;

    // Payload bytes plus the 8-byte UDP header
    localparam logic [15:0] UDP_LENGTH = 16'(FRAME_WORDS * 8 + 8);

    logic frame_start_q;
    logic last_fire;
    logic hdr_fire;

    assign last_fire = tx_payload_valid && tx_payload_ready && tx_payload_last;
    assign hdr_fire  = tx_hdr_valid && tx_hdr_ready;

    // Armed for the next frame once the current one ends
    always_ff @(posedge clk) begin
        if (rst) begin
            frame_start_q <= 1'b1;
        end else if (last_fire) begin
            frame_start_q <= 1'b1;
        end else if (hdr_fire) begin
            frame_start_q <= 1'b0;
        end
    end

    // Header shows up together with the first word of a frame
    assign tx_hdr_valid = frame_start_q && tx_payload_valid;

    assign tx_hdr = '{
        dest_ip:     reply_ip,
        source_ip:   LOCAL_IP,
        source_port: TX_SOURCE_PORT,
        dest_port:   TX_DEST_PORT,
        length:      UDP_LENGTH,
        ttl:         TX_TTL
    };

endmodule

`default_nettype wire

/* tests/tb_clock_gen.sv */
// Testbench clock and synchronous reset source; instantiated once by the testbench top
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
    parameter real PERIOD_NS    = 8.0,
    parameter int  RESET_CYCLES = 16
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

    // Released just after an edge like the other driven inputs
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

`default_nettype wire

/* tests/tb_udp_pattern.sv */
// Testbench for the UDP pattern source; sends commands, applies random back-pressure, checks output
`timescale 1ns/100ps
`default_nettype none

module tb_udp_pattern;
    import udp_pattern_pkg::*;

    localparam int          FRAME_WORDS = 16;
    localparam logic [31:0] LFSR_SEED   = 32'h47a0ff7c;

    logic         clk;
    logic         rst;
    udp_rx_hdr_t  rx_hdr;
    logic         rx_hdr_valid;
    axis_word_t   rx_payload;
    logic         rx_payload_valid;
    udp_tx_hdr_t  tx_hdr;
    logic         tx_hdr_valid;
    logic         tx_hdr_ready;
    axis_word_t   tx_payload;
    logic         tx_payload_valid;
    logic         tx_payload_ready;
    logic         running;

    logic [31:0]  lfsr_state;
    int           cycle_count;
    int           words_seen;
    int           hdr_count;
    int           start_cycle;
    int           stop_cycle;
    logic         prev_valid;
    ip_addr_t     exp_reply_ip;

    tb_clock_gen #(
        .PERIOD_NS    (8.0),
        .RESET_CYCLES (16)
    ) u_clock_gen (
        .clk (clk),
        .rst (rst)
    );

    udp_pattern_top #(
        .FRAME_WORDS (FRAME_WORDS)
    ) UUT (
        .clk              (clk),
        .rst              (rst),
        .rx_hdr           (rx_hdr),
        .rx_hdr_valid     (rx_hdr_valid),
        .rx_payload       (rx_payload),
        .rx_payload_valid (rx_payload_valid),
        .tx_hdr           (tx_hdr),
        .tx_hdr_valid     (tx_hdr_valid),
        .tx_hdr_ready     (tx_hdr_ready),
        .tx_payload       (tx_payload),
        .tx_payload_valid (tx_payload_valid),
        .tx_payload_ready (tx_payload_ready),
        .running          (running)
    );

    function automatic logic [31:0] galois_next(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end
        return state >> 1;
    endfunction

    task automatic take_bit(output logic b);
        lfsr_state = galois_next(lfsr_state);
        b = lfsr_state[0];
    endtask

    // Text literal to wire order with the first character in the low byte
    function automatic data_word_t ascii_word(input logic [63:0] text);
        data_word_t w;
        for (int i = 0; i < 8; i++) begin
            w[8*i +: 8] = text[8*(7-i) +: 8];
        end
        return w;
    endfunction

    // Expected stream word for a global word index
    function automatic data_word_t expected_word(input int idx);
        if (idx == 0) begin
            return ascii_word("\n.INIT.\n");
        end
        case ((idx - 1) % 8)
            0: return ascii_word("ABCDEFGH");
            1: return ascii_word("IJKLMNOP");
            2: return ascii_word("QRSTUVWX");
            3: return ascii_word("YZ[\\]^_\n");
            4: return ascii_word("abcdefgh");
            5: return ascii_word("ijklmnop");
            6: return ascii_word("qrstuvwx");
            default: return ascii_word({"yz{|}~", 8'h7F, "\n"});
        endcase
    endfunction

    task automatic fail_run();
        $display("Finished with errors");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_equal(input string what, input logic [127:0] actual,
                               input logic [127:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s: got %0h, expected %0h",
                     $time, what, actual, expected);
            fail_run();
        end
    endtask

    task automatic timeout_fail(input string what);
        $display("Timeout while waiting for %s", what);
        fail_run();
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    // Random ready on both transmit channels
    initial begin : ready_driver
        logic b;
        lfsr_state       = LFSR_SEED;
        tx_payload_ready = 1'b0;
        tx_hdr_ready     = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            take_bit(b);
            tx_payload_ready = b;
            take_bit(b);
            tx_hdr_ready = b;
        end
    end

    // Monitor sampled mid-cycle where everything is settled
    always @(negedge clk) begin
        udp_tx_hdr_t exp_hdr;
        if (!rst) begin
            if (tx_payload_valid && !prev_valid) begin
                check_equal("cycle of first valid", cycle_count, start_cycle + 2);
            end
            if (cycle_count >= stop_cycle + 2) begin
                check_equal("payload valid after stop", tx_payload_valid, 1'b0);
                check_equal("header valid after stop", tx_hdr_valid, 1'b0);
            end
            if (tx_hdr_valid && tx_hdr_ready) begin
                exp_hdr = '{
                    dest_ip:     exp_reply_ip,
                    source_ip:   {8'd192, 8'd168, 8'd1, 8'd128},
                    source_port: 16'd1234,
                    dest_port:   16'd9999,
                    length:      16'd136,
                    ttl:         8'd64
                };
                check_equal("frame of accepted header", words_seen / FRAME_WORDS, hdr_count);
                check_equal("header fields", tx_hdr, exp_hdr);
                hdr_count = hdr_count + 1;
            end
            if (tx_payload_valid && tx_payload_ready) begin
                check_equal("payload data", tx_payload.data, expected_word(words_seen));
                check_equal("payload keep", tx_payload.keep, 8'hFF);
                check_equal("payload last", tx_payload.last,
                            (words_seen % FRAME_WORDS) == FRAME_WORDS - 1);
                if (tx_payload.last) begin
                    check_equal("headers at frame end", hdr_count,
                                words_seen / FRAME_WORDS + 1);
                end
                words_seen = words_seen + 1;
            end
            prev_valid = tx_payload_valid;
        end
    end

    task automatic wait_for_reset_release(input int limit);
        int n;
        n = 0;
        while (rst && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (rst) begin
            timeout_fail("reset release");
        end
    endtask

    task automatic wait_for_words(input int count, input int limit);
        int n;
        n = 0;
        while (words_seen < count && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (words_seen < count) begin
            timeout_fail("payload words to be transferred");
        end
    endtask

    task automatic idle_checks(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            check_equal("running while idle", running, 1'b0);
            check_equal("payload valid while idle", tx_payload_valid, 1'b0);
            check_equal("header valid while idle", tx_hdr_valid, 1'b0);
        end
    endtask

    // Two-word datagram; reports the cycle of the first payload word
    task automatic send_datagram(input ip_addr_t src, input udp_port_t port,
                                 input data_word_t first_word, input data_word_t second_word,
                                 input logic hdr_early, output int first_cycle);
        @(posedge clk);
        #1;
        rx_hdr       = '{source_ip: src, dest_port: port};
        rx_hdr_valid = 1'b1;
        if (hdr_early) begin
            @(posedge clk);
            #1;
            rx_hdr_valid = 1'b0;
        end
        rx_payload       = '{data: first_word, keep: 8'hFF, last: 1'b0};
        rx_payload_valid = 1'b1;
        first_cycle      = cycle_count;
        @(posedge clk);
        #1;
        rx_hdr_valid     = 1'b0;
        rx_payload       = '{data: second_word, keep: 8'hFF, last: 1'b1};
        @(posedge clk);
        #1;
        rx_payload_valid = 1'b0;
        rx_payload       = '0;
    endtask

    initial begin : stimulus
        int first_cycle;
        rx_hdr           = '0;
        rx_hdr_valid     = 1'b0;
        rx_payload       = '0;
        rx_payload_valid = 1'b0;
        cycle_count      = 0;
        words_seen       = 0;
        hdr_count        = 0;
        start_cycle      = -100;
        stop_cycle       = 32'h7FFF_FF00;
        prev_valid       = 1'b0;
        exp_reply_ip     = {8'd192, 8'd168, 8'd1, 8'd100};

        wait_for_reset_release(100);
        idle_checks(20);

        // Start on a foreign port
        send_datagram({8'd10, 8'd0, 8'd0, 8'd5}, 16'd5000, ascii_word("....INIT"),
                      ascii_word("filler.."), 1'b0, first_cycle);
        idle_checks(8);
        check_equal("reply address after foreign port", UUT.u_command_decoder.reply_ip,
                    {8'd192, 8'd168, 8'd1, 8'd100});

        // Right port but broken marker
        send_datagram({8'd10, 8'd0, 8'd0, 8'd7}, 16'd1234, ascii_word("..-.INIT"),
                      ascii_word("filler.."), 1'b1, first_cycle);
        idle_checks(8);

        // Second word holds a stop that has to be ignored
        exp_reply_ip = {8'd192, 8'd168, 8'd1, 8'd50};
        send_datagram(exp_reply_ip, 16'd1234, ascii_word("....INIT"),
                      ascii_word("....FINI"), 1'b0, first_cycle);
        start_cycle = first_cycle;

        wait_for_words(5 * FRAME_WORDS + 7, 2000);
        check_equal("running while streaming", running, 1'b1);

        send_datagram(exp_reply_ip, 16'd1234, ascii_word("....FINI"),
                      ascii_word("....INIT"), 1'b1, first_cycle);
        stop_cycle = first_cycle;

        repeat (40) @(negedge clk);
        check_equal("running after stop", running, 1'b0);
        check_equal("headers for started frames", hdr_count,
                    (words_seen + FRAME_WORDS - 1) / FRAME_WORDS);

        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire
